// ==== include/bram_writer_consts.svh ====
`ifndef BRAM_WRITER_CONSTS_SVH
`define BRAM_WRITER_CONSTS_SVH

// AXI4-Lite write channel widths
`define AXI_DATA_WIDTH 32
`define AXI_STRB_WIDTH 4
`define AXI_ADDR_WIDTH 16

// RAM geometry, 1024 words of 32 bits
`define BRAM_ADDR_WIDTH 10

// Byte address bit where the word address starts
`define ADDR_LSB 2

`endif

// ==== hdl/bram_writer_pkg.sv ====
`default_nettype none

package bram_writer_pkg;

  // AXI write response codes as carried on bresp
  typedef enum logic [1:0] {
    OKAY   = 2'b00,  // Normal write done
    EXOKAY = 2'b01,  // Exclusive access, unused by this slave
    SLVERR = 2'b10,  // Address beyond the RAM, nothing written
    DECERR = 2'b11   // Decode error, unused by this slave
  } axi_resp_e;

endpackage

`default_nettype wire

// ==== hdl/input_buffer.sv ====
`default_nettype none

module input_buffer #(
  parameter int DATA_WIDTH = 32
) (
  input  wire logic                  aclk,
  input  wire logic                  arst_n,
  input  wire logic [DATA_WIDTH-1:0] in_data,
  input  wire logic                  in_valid,
  output logic                       in_ready,
  output logic [DATA_WIDTH-1:0]      out_data,
  output logic                       out_valid,
  input  wire logic                  out_ready
);

  logic [DATA_WIDTH-1:0] skid_data;   // Beat parked while downstream stalls
  logic                  skid_valid;
  logic                  skid_load;

  // Park the incoming beat when it cannot go straight through
  assign skid_load = in_valid & ~skid_valid & ~out_ready;

  assign in_ready  = ~skid_valid;  // Registered ready
  assign out_valid = skid_valid | in_valid;
  assign out_data  = skid_valid ? skid_data : in_data;  // Parked beat goes first

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      skid_valid <= 1'b0;
    end else if (skid_valid) begin
      if (out_ready) begin
        skid_valid <= 1'b0;  // Parked beat consumed
      end
    end else if (skid_load) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (skid_load) begin
      skid_data <= in_data;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/output_buffer.sv ====
`default_nettype none

module output_buffer import bram_writer_pkg::*; #(
  parameter int DATA_WIDTH = 2
) (
  input  wire logic                  aclk,
  input  wire logic                  arst_n,
  input  wire logic [DATA_WIDTH-1:0] in_data,
  input  wire logic                  in_valid,
  output logic                       in_ready,
  output logic [DATA_WIDTH-1:0]      out_data,
  output logic                       out_valid,
  input  wire logic                  out_ready
);

  logic [DATA_WIDTH-1:0] data_q;
  logic                  valid_q;

  // Room when empty or when the held item leaves this cycle
  assign in_ready  = ~valid_q | out_ready;
  assign out_valid = valid_q;
  assign out_data  = data_q;

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else if (in_ready) begin
      valid_q <= in_valid;  // Reload on the same edge it drains
    end
  end

  // Idle output reads as OKAY until the first item arrives
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      data_q <= DATA_WIDTH'(OKAY);
    end else if (in_ready && in_valid) begin
      data_q <= in_data;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/axi_bram_writer.sv ====
`default_nettype none

`include "bram_writer_consts.svh"

module axi_bram_writer import bram_writer_pkg::*; (
  input  wire logic                        aclk,
  input  wire logic                        arst_n,

  input  wire logic [`AXI_ADDR_WIDTH-1:0]  awaddr,
  input  wire logic                        awvalid,
  output logic                             awready,
  input  wire logic [`AXI_DATA_WIDTH-1:0]  wdata,
  input  wire logic [`AXI_STRB_WIDTH-1:0]  wstrb,
  input  wire logic                        wvalid,
  output logic                             wready,
  output axi_resp_e                        bresp,
  output logic                             bvalid,
  input  wire logic                        bready,

  output logic [`BRAM_ADDR_WIDTH-1:0]      bram_addr,
  output logic [`AXI_DATA_WIDTH-1:0]       bram_wrdata,
  output logic [`AXI_STRB_WIDTH-1:0]       bram_we
);

  logic [`AXI_ADDR_WIDTH-1:0]                 aw_q;
  logic                                       aw_q_valid;
  logic                                       aw_pop_ready;
  logic [`AXI_STRB_WIDTH+`AXI_DATA_WIDTH-1:0] w_q;
  logic                                       w_q_valid;
  logic                                       w_pop_ready;
  logic [`AXI_STRB_WIDTH-1:0]                 w_q_strb;
  logic [`AXI_DATA_WIDTH-1:0]                 w_q_data;
  logic                                       resp_ready;
  logic                                       pop;
  logic                                       in_range;
  axi_resp_e                                  resp;
  logic [1:0]                                 bresp_raw;

  // Each side drains only when its partner is ready and the response has room
  assign aw_pop_ready = w_q_valid & resp_ready;
  assign w_pop_ready  = aw_q_valid & resp_ready;
  assign pop          = aw_q_valid & w_q_valid & resp_ready;

  assign {w_q_strb, w_q_data} = w_q;

  // Anything above the RAM's byte span is out of range
  assign in_range = (aw_q[`AXI_ADDR_WIDTH-1:`ADDR_LSB+`BRAM_ADDR_WIDTH] == '0);
  assign resp     = in_range ? OKAY : SLVERR;

  input_buffer #(
    .DATA_WIDTH (`AXI_ADDR_WIDTH)
  ) u_aw_buf (
    .aclk      (aclk),
    .arst_n    (arst_n),
    .in_data   (awaddr),
    .in_valid  (awvalid),
    .in_ready  (awready),
    .out_data  (aw_q),
    .out_valid (aw_q_valid),
    .out_ready (aw_pop_ready)
  );

  input_buffer #(
    .DATA_WIDTH (`AXI_STRB_WIDTH + `AXI_DATA_WIDTH)
  ) u_w_buf (
    .aclk      (aclk),
    .arst_n    (arst_n),
    .in_data   ({wstrb, wdata}),
    .in_valid  (wvalid),
    .in_ready  (wready),
    .out_data  (w_q),
    .out_valid (w_q_valid),
    .out_ready (w_pop_ready)
  );

  output_buffer #(
    .DATA_WIDTH (2)
  ) u_b_buf (
    .aclk      (aclk),
    .arst_n    (arst_n),
    .in_data   (resp),
    .in_valid  (pop),
    .in_ready  (resp_ready),
    .out_data  (bresp_raw),
    .out_valid (bvalid),
    .out_ready (bready)
  );

  assign bresp = axi_resp_e'(bresp_raw);

  // RAM port A, written only on the pairing edge
  assign bram_addr   = aw_q[`ADDR_LSB+`BRAM_ADDR_WIDTH-1:`ADDR_LSB];
  assign bram_wrdata = w_q_data;
  assign bram_we     = (pop && in_range) ? w_q_strb : '0;  // Dropped writes leave RAM alone

endmodule

`default_nettype wire

// ==== hdl/bram_dual_port.sv ====
`default_nettype none

`include "bram_writer_consts.svh"

module bram_dual_port #(
  parameter int ADDR_WIDTH = `BRAM_ADDR_WIDTH,
  parameter int DATA_WIDTH = `AXI_DATA_WIDTH
) (
  input  wire logic                    aclk,
  input  wire logic [ADDR_WIDTH-1:0]   a_addr,
  input  wire logic [DATA_WIDTH-1:0]   a_wrdata,
  input  wire logic [DATA_WIDTH/8-1:0] a_we,      // One enable per byte
  input  wire logic [ADDR_WIDTH-1:0]   b_addr,
  output logic [DATA_WIDTH-1:0]        b_rddata
);

  localparam int DEPTH = 1 << ADDR_WIDTH;

  logic [DATA_WIDTH-1:0] mem [DEPTH];

  // Port A byte writes
  always_ff @(posedge aclk) begin
    for (int i = 0; i < DATA_WIDTH / 8; i++) begin
      if (a_we[i]) begin
        mem[a_addr][i*8 +: 8] <= a_wrdata[i*8 +: 8];
      end
    end
  end

  // Port B sees the old word on a same-address collision
  always_ff @(posedge aclk) begin
    b_rddata <= mem[b_addr];
  end

endmodule

`default_nettype wire

// ==== hdl/bram_writer_top.sv ====
`default_nettype none

`include "bram_writer_consts.svh"

module bram_writer_top import bram_writer_pkg::*; (
  input  wire logic                        aclk,
  input  wire logic                        arst_n,

  input  wire logic [`AXI_ADDR_WIDTH-1:0]  awaddr,
  input  wire logic                        awvalid,
  output logic                             awready,
  input  wire logic [`AXI_DATA_WIDTH-1:0]  wdata,
  input  wire logic [`AXI_STRB_WIDTH-1:0]  wstrb,
  input  wire logic                        wvalid,
  output logic                             wready,
  output axi_resp_e                        bresp,
  output logic                             bvalid,
  input  wire logic                        bready,

  input  wire logic [`BRAM_ADDR_WIDTH-1:0] rd_addr,  // Readback word address
  output logic [`AXI_DATA_WIDTH-1:0]       rd_data
);

  logic [`BRAM_ADDR_WIDTH-1:0] ram_addr;
  logic [`AXI_DATA_WIDTH-1:0]  ram_wrdata;
  logic [`AXI_STRB_WIDTH-1:0]  ram_we;

  axi_bram_writer u_writer (
    .aclk        (aclk),
    .arst_n      (arst_n),
    .awaddr      (awaddr),
    .awvalid     (awvalid),
    .awready     (awready),
    .wdata       (wdata),
    .wstrb       (wstrb),
    .wvalid      (wvalid),
    .wready      (wready),
    .bresp       (bresp),
    .bvalid      (bvalid),
    .bready      (bready),
    .bram_addr   (ram_addr),
    .bram_wrdata (ram_wrdata),
    .bram_we     (ram_we)
  );

  bram_dual_port #(
    .ADDR_WIDTH (`BRAM_ADDR_WIDTH),
    .DATA_WIDTH (`AXI_DATA_WIDTH)
  ) u_ram (
    .aclk     (aclk),
    .a_addr   (ram_addr),
    .a_wrdata (ram_wrdata),
    .a_we     (ram_we),
    .b_addr   (rd_addr),
    .b_rddata (rd_data)
  );

endmodule

`default_nettype wire

// ==== sim/bram_writer_assert.sv ====
`default_nettype none

`include "bram_writer_consts.svh"

module bram_writer_assert (
  input wire logic                       aclk,
  input wire logic                       arst_n,
  input wire logic [`AXI_ADDR_WIDTH-1:0] awaddr,
  input wire logic                       awvalid,
  input wire logic                       awready,
  input wire logic [1:0]                 bresp,
  input wire logic                       bvalid,
  input wire logic                       bready,
  input wire logic [`AXI_STRB_WIDTH-1:0] bram_we
);

  timeunit 1ns;
  timeprecision 1ps;

  // A stalled response holds still
  assert property (@(posedge aclk) disable iff (!arst_n)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else $error("B channel changed while bready was low");

  assert property (@(posedge aclk) disable iff (!arst_n)
    awvalid && !awready |=> awvalid && $stable(awaddr))
    else $error("AW channel dropped or changed before awready");

  // Any RAM write comes with a pushed response
  assert property (@(posedge aclk) disable iff (!arst_n)
    bram_we != '0 |=> bvalid)
    else $error("RAM written without a following write response");

  assert property (@(posedge aclk) !arst_n |-> !bvalid)
    else $error("bvalid high during reset");

endmodule

bind axi_bram_writer bram_writer_assert u_assert (
  .aclk    (aclk),
  .arst_n  (arst_n),
  .awaddr  (awaddr),
  .awvalid (awvalid),
  .awready (awready),
  .bresp   (bresp),
  .bvalid  (bvalid),
  .bready  (bready),
  .bram_we (bram_we)
);

`default_nettype wire

// ==== sim/tb_bram_writer.sv ====
`default_nettype none

`include "bram_writer_consts.svh"

module tb_bram_writer import bram_writer_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_OPS   = 128;
  localparam int DRIVE_DLY = 2;  // Inputs change this long after the rising edge

  logic                        aclk;
  logic                        arst_n;
  logic [`AXI_ADDR_WIDTH-1:0]  awaddr;
  logic                        awvalid;
  logic                        awready;
  logic [`AXI_DATA_WIDTH-1:0]  wdata;
  logic [`AXI_STRB_WIDTH-1:0]  wstrb;
  logic                        wvalid;
  logic                        wready;
  axi_resp_e                   bresp;
  logic                        bvalid;
  logic                        bready;
  logic [`BRAM_ADDR_WIDTH-1:0] rd_addr;
  logic [`AXI_DATA_WIDTH-1:0]  rd_data;

  logic [7:0]                 op_kind [MAX_OPS];
  logic [`AXI_ADDR_WIDTH-1:0] op_addr [MAX_OPS];  // Byte address for W, word address for R
  logic [`AXI_DATA_WIDTH-1:0] op_data [MAX_OPS];  // Write data or expected read data
  logic [`AXI_STRB_WIDTH-1:0] op_strb [MAX_OPS];
  logic [1:0]                 op_resp [MAX_OPS];
  int                         op_aw_dly [MAX_OPS];
  int                         op_w_dly [MAX_OPS];
  int                         op_stall [MAX_OPS];  // Cycles bready stays low
  int                         n_ops;
  int                         n_writes;

  integer seed        = 7204;
  int     value_errs  = 0;
  int     other_errs  = 0;
  int     resp_seen   = 0;
  int     cycle_count = 0;
  int     cycle_limit = 0;

  bram_writer_top i_dut (
    .aclk    (aclk),
    .arst_n  (arst_n),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  initial begin
    aclk = 1'b0;
    forever #20 aclk = ~aclk;
  end

  always @(posedge aclk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("Timeout, the run did not finish within %0d cycles", cycle_limit);
      other_errs++;
      finish_run(1'b1);
    end
  end

  // Mid-cycle view of every B handshake
  always @(negedge aclk) begin
    if (arst_n && bvalid && bready) begin
      resp_seen++;
    end
  end

  task automatic finish_run(input logic timed_out);
    $display("Error count: %0d wrong values, %0d other", value_errs, other_errs);
    if (timed_out || value_errs != 0 || other_errs != 0) begin
      $display("Done: errors found");
    end else begin
      $display("Done: no errors");
    end
    $finish;
  endtask

  task automatic next_cycle();
    @(posedge aclk);
    #DRIVE_DLY;
  endtask

  task automatic load_trace();
    int                         fd;
    int                         code;
    logic [7:0]                 tok;
    logic [8*160-1:0]           rest;
    logic [`AXI_ADDR_WIDTH-1:0] a;
    logic [`AXI_DATA_WIDTH-1:0] d;
    logic [`AXI_STRB_WIDTH-1:0] s;
    logic [1:0]                 r;
    int                         aw_dly;
    int                         w_dly;
    int                         stall;
    n_ops    = 0;
    n_writes = 0;
    fd = $fopen("sim/bram_writer_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file sim/bram_writer_trace.txt");
      other_errs++;
      return;
    end
    forever begin
      code = $fscanf(fd, "%s", tok);
      if (code != 1) begin
        break;
      end
      if (tok == "#") begin
        code = $fgets(rest, fd);  // Skip the rest of a comment line
        continue;
      end
      if (n_ops >= MAX_OPS) begin
        $display("Trace holds more than %0d operations", MAX_OPS);
        other_errs++;
        break;
      end
      s      = '0;
      r      = 2'b00;
      aw_dly = 0;
      w_dly  = 0;
      stall  = 0;
      if (tok == "W") begin
        code = $fscanf(fd, "%h %h %h %h %d %d %d", a, d, s, r, aw_dly, w_dly, stall);
        n_writes++;
        if (code != 7) begin
          $display("Write line %0d of the trace is malformed", n_ops + 1);
          other_errs++;
          break;
        end
      end else if (tok == "R") begin
        code = $fscanf(fd, "%h %h", a, d);
        if (code != 2) begin
          $display("Read line %0d of the trace is malformed", n_ops + 1);
          other_errs++;
          break;
        end
      end else begin
        $display("Unknown operation in trace entry %0d", n_ops + 1);
        other_errs++;
        break;
      end
      op_kind[n_ops]   = tok;
      op_addr[n_ops]   = a;
      op_data[n_ops]   = d;
      op_strb[n_ops]   = s;
      op_resp[n_ops]   = r;
      op_aw_dly[n_ops] = aw_dly;
      op_w_dly[n_ops]  = w_dly;
      op_stall[n_ops]  = stall;
      n_ops++;
    end
    $fclose(fd);
  endtask

  task automatic drive_aw(input int first, input int last);
    logic taken;
    for (int k = first; k < last; k++) begin
      repeat (op_aw_dly[k]) next_cycle();
      awaddr  = op_addr[k];
      awvalid = 1'b1;
      do begin
        @(negedge aclk);
        taken = awready;
        next_cycle();
      end while (!taken);
      awvalid = 1'b0;
    end
  endtask

  task automatic drive_w(input int first, input int last);
    logic taken;
    for (int k = first; k < last; k++) begin
      repeat (op_w_dly[k]) next_cycle();
      wdata  = op_data[k];
      wstrb  = op_strb[k];
      wvalid = 1'b1;
      do begin
        @(negedge aclk);
        taken = wready;
        next_cycle();
      end while (!taken);
      wvalid = 1'b0;
    end
  endtask

  // Responses must come back in write order
  task automatic collect_b(input int first, input int last);
    int        gap;
    logic      seen;
    axi_resp_e got;
    for (int k = first; k < last; k++) begin
      bready = 1'b0;
      gap    = $random(seed) & 3;  // Extra stall on top of the trace value
      repeat (op_stall[k] + gap) next_cycle();
      bready = 1'b1;
      do begin
        @(negedge aclk);
        seen = bvalid;
        got  = bresp;
        next_cycle();
      end while (!seen);
      assert (got == axi_resp_e'(op_resp[k])) else begin
        $display("[FAIL] bresp: trace entry %0d expected %h got %h", k + 1, op_resp[k], got);
        value_errs++;
      end
    end
    bready = 1'b0;
  endtask

  task automatic check_read(input int k);
    rd_addr = op_addr[k][`BRAM_ADDR_WIDTH-1:0];
    @(posedge aclk);  // Port B samples the address here
    @(negedge aclk);
    assert (rd_data == op_data[k]) else begin
      $display("[FAIL] rd_data: word %h expected %h got %h", rd_addr, op_data[k], rd_data);
      value_errs++;
    end
    next_cycle();
  endtask

  task automatic check_idle();
    @(negedge aclk);
    assert (!bvalid && awready && wready) else begin
      $display("[FAIL] bvalid/awready/wready: expected 0/1/1 got %h/%h/%h",
               bvalid, awready, wready);
      value_errs++;
    end
    next_cycle();
  endtask

  initial begin
    int k;
    int first;
    arst_n  = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    rd_addr = '0;
    load_trace();
    cycle_limit = 40 * n_ops + 200;
    repeat (3) @(posedge aclk);
    #DRIVE_DLY;
    arst_n = 1'b1;
    check_idle();
    k = 0;
    while (k < n_ops) begin
      if (op_kind[k] == "R") begin
        check_read(k);
        k++;
      end else begin
        first = k;  // A run of writes goes out as one batch
        while (k < n_ops && op_kind[k] == "W") begin
          k++;
        end
        fork
          drive_aw(first, k);
          drive_w(first, k);
          collect_b(first, k);
        join
      end
    end
    bready = 1'b1;  // Any response still held shows up in the count
    repeat (4) next_cycle();
    bready = 1'b0;
    assert (resp_seen == n_writes) else begin
      $display("Got %0d write responses for %0d writes", resp_seen, n_writes);
      other_errs++;
    end
    finish_run(1'b0);
  end

endmodule

`default_nettype wire

// ==== sim/bram_writer_trace.txt ====
# W byte_addr(hex) data(hex) strb(hex) resp(hex) aw_delay wr_delay bready_stall (cycles)
# R word_addr(hex) expected_data(hex)
W 0000 11111111 f 0 0 0 0
W 0004 22222222 f 0 0 0 0
W 0100 a5a5a5a5 f 0 0 0 0
W 0ffc deadbeef f 0 0 0 0
R 000 11111111
R 001 22222222
R 040 a5a5a5a5
R 3ff deadbeef
W 0004 0000abcd 3 0 1 0 0
W 0100 77000000 8 0 0 2 1
W 0ffc 00330000 4 0 0 0 0
R 001 2222abcd
R 040 77a5a5a5
R 3ff de33beef
W 1000 ffffffff f 2 0 0 0
W 2004 ffffffff f 2 0 0 1
W fffc 12345678 f 2 0 0 0
R 000 11111111
R 001 2222abcd
R 3ff de33beef
W 0010 10101010 f 0 0 5 0
W 0014 14141414 f 0 6 0 0
W 0018 18181818 f 0 3 0 0
R 004 10101010
R 005 14141414
R 006 18181818
W 0020 20202020 f 0 0 0 6
W 0024 24242424 f 0 0 0 0
W 0028 28282828 f 0 0 0 0
W 002c 2c2c2c2c f 0 0 0 4
W 1028 ffffffff f 2 0 0 0
W 0034 34343434 f 0 0 0 0
R 008 20202020
R 009 24242424
R 00a 28282828
R 00b 2c2c2c2c
R 00d 34343434

// ==== list.f ====
+incdir+include
hdl/bram_writer_pkg.sv
hdl/input_buffer.sv
hdl/output_buffer.sv
hdl/axi_bram_writer.sv
hdl/bram_dual_port.sv
hdl/bram_writer_top.sv
sim/bram_writer_assert.sv
sim/tb_bram_writer.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module tb_bram_writer \
  -Mdir "$BUILD_DIR" -o sim_bram_writer > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim_bram_writer" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Done: no errors" "$SIM_LOG"; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1
